/* rtl/mem_bus_pkg.sv */
// instruction memory bus definitions
// widths, word and address types, and the sequential fetch step
package mem_bus_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // byte address presented to the instruction memory
  localparam int unsigned ADDR_W = 32;

  // one instruction word per response
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

  ////////////////////////////////////////
  // sequential fetch
  ////////////////////////////////////////

  // distance in bytes between two consecutive instruction words
  localparam addr_t ADDR_STEP = 32'd4;

  // the last address is word aligned before the step is added
  localparam int unsigned ALIGN_BITS = 2;

endpackage

/* rtl/fetch_pkg.sv */
// prefetch control definitions
// fetch FSM state encoding and the FIFO sizing rule shared by the
// control and storage blocks
package fetch_pkg;

  ////////////////////////////////////////
  // fetch FSM states
  ////////////////////////////////////////

  // IDLE          no request outstanding
  // WAIT_GNT      request raised, memory has not granted it yet
  // WAIT_RVALID   request granted, response still to come
  // WAIT_ABORTED  a branch arrived while a response was pending,
  //               that response is thrown away
  // WAIT_JUMP     protection error seen, blocked until the next branch
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED,
    WAIT_JUMP
  } fetch_state_t;

  // below two entries the space flag would never allow a request
  localparam int unsigned MIN_FIFO_DEPTH = 2;

endpackage

/* rtl/fetch_ctrl.sv */
// fetch control for the prefetch buffer
// runs the memory side FSM, keeps the last address sent and picks the
// address of the next request (sequential step or branch target)
module fetch_ctrl
  import mem_bus_pkg::*;
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_i,
  input  logic         branch_i,
  input  addr_t        addr_i,
  input  logic         space_i,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  logic         instr_err_pmp_i,
  input  logic         valid_i,
  output logic         instr_req_o,
  output addr_t        instr_addr_o,
  output fetch_state_t state_o,
  output logic         flush_o,
  output logic         fetch_failed_o,
  output logic         busy_o
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  fetch_state_t issue_state;
  addr_t        addr_q;
  addr_t        seq_addr;
  logic         addr_en;
  logic         req_want;
  logic         fetch_go;

  ////////////////////////////////////////
  // address selection
  ////////////////////////////////////////

  // next word follows the last address sent, aligned to a word
  assign seq_addr = {addr_q[ADDR_W-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}} + ADDR_STEP;

  // a branch always fetches, a sequential fetch needs room in the FIFO
  assign fetch_go = branch_i | (req_i & space_i);

  // where the FSM goes once a request has been raised
  assign issue_state = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;

  ////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    req_want       = 1'b0;
    addr_en        = 1'b0;
    fetch_failed_o = 1'b0;
    // a branch target always replaces the sequential address
    instr_addr_o   = branch_i ? addr_i : seq_addr;

    case (state_q)
      IDLE: begin
        if (fetch_go) begin
          req_want = 1'b1;
          addr_en  = 1'b1;
          state_d  = issue_state;
        end
      end

      WAIT_GNT: begin
        // hold the pending address unless the core redirects us
        if (!branch_i) begin
          instr_addr_o = addr_q;
        end
        req_want = 1'b1;
        addr_en  = branch_i;
        if (instr_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // response arrives now, so the next request may go out with it
          if (fetch_go) begin
            req_want = 1'b1;
            addr_en  = 1'b1;
            state_d  = issue_state;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          // remember the target and drop the response still in flight
          addr_en = 1'b1;
          state_d = WAIT_ABORTED;
        end
      end

      WAIT_ABORTED: begin
        // addr_q already holds the target, a newer branch overrides it
        if (!branch_i) begin
          instr_addr_o = addr_q;
        end
        addr_en = branch_i;
        if (instr_rvalid_i) begin
          req_want = 1'b1;
          state_d  = issue_state;
        end
      end

      WAIT_JUMP: begin
        // words already buffered are still handed out before the flag shows
        fetch_failed_o = ~valid_i;
        if (branch_i) begin
          req_want       = 1'b1;
          addr_en        = 1'b1;
          fetch_failed_o = 1'b0;
          state_d        = issue_state;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // a protected address never reaches memory and blocks the fetch
    if (req_want && instr_err_pmp_i) begin
      state_d = WAIT_JUMP;
    end
  end

  assign instr_req_o = req_want & ~instr_err_pmp_i;
  assign flush_o     = branch_i;
  assign state_o     = state_q;
  assign busy_o      = (state_q != IDLE) | instr_req_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_en) begin
        addr_q <= instr_addr_o;
      end
    end
  end

endmodule

/* rtl/instr_fifo.sv */
// instruction FIFO of the prefetch buffer
// circular buffer with flush, usage count and an early space flag
module instr_fifo
  import mem_bus_pkg::*;
  import fetch_pkg::*;
#(
  parameter int unsigned DEPTH = 3
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  flush_i,
  input  logic  push_i,
  input  word_t data_i,
  input  logic  pop_i,
  output word_t head_o,
  output logic  not_empty_o,
  output logic  space_o
);

  // depths below the minimum are raised to it
  localparam int unsigned EFF_DEPTH = (DEPTH < MIN_FIFO_DEPTH) ? MIN_FIFO_DEPTH : DEPTH;
  localparam int unsigned PTR_W     = $clog2(EFF_DEPTH);
  localparam int unsigned CNT_W     = $clog2(EFF_DEPTH + 1);

  word_t            mem [EFF_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] usage;
  logic             do_push;
  logic             do_pop;

  // pointer step that wraps at the last entry, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] last;
    last = PTR_W'(EFF_DEPTH - 1);
    return (ptr == last) ? '0 : ptr + 1'b1;
  endfunction

  // a flush wins over anything else in the same cycle
  assign do_push = push_i & ~flush_i & (usage != CNT_W'(EFF_DEPTH));
  assign do_pop  = pop_i & ~flush_i & (usage != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      usage  <= '0;
    end else if (flush_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      usage  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // simultaneous push and pop keep the count
      if (do_push && !do_pop) begin
        usage <= usage + 1'b1;
      end else if (do_pop && !do_push) begin
        usage <= usage - 1'b1;
      end
    end
  end

  // the entry under the write pointer takes the pushed word
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  assign head_o      = mem[rd_ptr];
  assign not_empty_o = (usage != '0);
  // one entry stays free for the response that may still be in flight
  assign space_o     = (usage < CNT_W'(EFF_DEPTH - 1));

endmodule

/* rtl/resp_path.sv */
// response path of the prefetch buffer
// hands the core either the FIFO head or the memory response directly,
// decides FIFO push and pop and drops responses of aborted requests
module resp_path
  import mem_bus_pkg::*;
  import fetch_pkg::*;
(
  input  fetch_state_t state_i,
  input  logic         instr_rvalid_i,
  input  word_t        instr_rdata_i,
  input  logic         not_empty_i,
  input  word_t        head_i,
  input  logic         ready_i,
  output logic         valid_o,
  output word_t        rdata_o,
  output logic         push_o,
  output logic         pop_o
);

  logic resp_live;

  // a response for an aborted request belongs to the old stream
  assign resp_live = instr_rvalid_i & (state_i != WAIT_ABORTED);

  always_comb begin
    if (not_empty_i) begin
      // older words first, the head is consumed when the core takes it
      valid_o = 1'b1;
      rdata_o = head_i;
      pop_o   = ready_i;
    end else begin
      // empty FIFO, memory data goes straight through
      valid_o = resp_live;
      rdata_o = instr_rdata_i;
      pop_o   = 1'b0;
    end
  end

  // store the response when it cannot overtake the FIFO or the core stalls
  assign push_o = resp_live & (not_empty_i | ~ready_i);

endmodule

/* rtl/prefetch_buffer.sv */
// instruction prefetch buffer
// fetches sequential words ahead of the core, redirects on branches and
// buffers words while the core applies back-pressure
module prefetch_buffer
  import mem_bus_pkg::*;
  import fetch_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 3
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_i,
  input  logic  branch_i,
  input  addr_t addr_i,
  input  logic  ready_i,
  output logic  valid_o,
  output word_t rdata_o,
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  output addr_t instr_addr_o,
  input  word_t instr_rdata_i,
  input  logic  instr_rvalid_i,
  input  logic  instr_err_pmp_i,
  output logic  fetch_failed_o,
  output logic  busy_o
);

  fetch_state_t state;
  logic         fifo_flush;
  logic         fifo_push;
  logic         fifo_pop;
  logic         fifo_space;
  logic         fifo_not_empty;
  word_t        fifo_head;

  // memory side FSM and address generation
  fetch_ctrl u_fetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .addr_i          (addr_i),
    .space_i         (fifo_space),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_err_pmp_i (instr_err_pmp_i),
    .valid_i         (valid_o),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .state_o         (state),
    .flush_o         (fifo_flush),
    .fetch_failed_o  (fetch_failed_o),
    .busy_o          (busy_o)
  );

  // words waiting for the core
  instr_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_instr_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (fifo_flush),
    .push_i      (fifo_push),
    .data_i      (instr_rdata_i),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .not_empty_o (fifo_not_empty),
    .space_o     (fifo_space)
  );

  // core side data selection
  resp_path u_resp_path (
    .state_i        (state),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .not_empty_i    (fifo_not_empty),
    .head_i         (fifo_head),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .push_o         (fifo_push),
    .pop_o          (fifo_pop)
  );

endmodule

/* bench/prefetch_props.sv */
// protocol checks for the prefetch buffer
// memory handshake and core side flag rules, bound to the top level
module prefetch_props
  import mem_bus_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  branch_i,
  input logic  instr_req_o,
  input logic  instr_gnt_i,
  input addr_t instr_addr_o,
  input logic  instr_rvalid_i,
  input logic  valid_o,
  input logic  fetch_failed_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic        outstanding;
  int unsigned assert_fails = 0;

  // a granted request owes exactly one response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      outstanding <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding <= 1'b0;
    end
  end

  // request and address stay put until granted, only a branch may redirect
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (branch_i || (instr_req_o && $stable(instr_addr_o))))
    else begin
      $error("request dropped or address changed before grant");
      assert_fails++;
    end

  rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> outstanding)
    else begin
      $error("response without an earlier grant");
      assert_fails++;
    end

  // after a failed fetch exactly one of the flag and a buffered word shows
  // until the next branch
  valid_xor_failed: assert property (@(posedge clk) disable iff (!rst_n)
    (fetch_failed_o && !branch_i) |=> (branch_i || (fetch_failed_o != valid_o)))
    else begin
      $error("fetch_failed_o not exclusive of valid_o or dropped before a branch");
      assert_fails++;
    end

endmodule

bind prefetch_buffer prefetch_props u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .branch_i       (branch_i),
  .instr_req_o    (instr_req_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_addr_o   (instr_addr_o),
  .instr_rvalid_i (instr_rvalid_i),
  .valid_o        (valid_o),
  .fetch_failed_o (fetch_failed_o)
);

/* bench/tb_prefetch.sv */
// testbench for the instruction prefetch buffer
// memory model with random grant and response delays, commands and
// expected streams from a data file, scoreboard on the core side
module tb_prefetch
  import mem_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned FIFO_DEPTH = 3;
  localparam word_t       DATA_KEY   = 32'hA5A5_0000;
  localparam int          CMD_BRANCH = 0;
  localparam int          CMD_ABORT  = 1;
  localparam int          CMD_STALL  = 2;
  localparam int          CMD_PMP    = 3;

  logic  clk;
  logic  rst_n;
  logic  req_i;
  logic  branch_i;
  addr_t addr_i;
  logic  ready_i;
  logic  valid_o;
  word_t rdata_o;
  logic  instr_req_o;
  logic  instr_gnt_i;
  addr_t instr_addr_o;
  word_t instr_rdata_i;
  logic  instr_rvalid_i;
  logic  instr_err_pmp_i;
  logic  fetch_failed_o;
  logic  busy_o;

  // command list and the addresses the memory refuses
  int    cmd_kind[$];
  addr_t cmd_addr[$];
  int    cmd_num[$];
  addr_t protected_q[$];

  // memory model state, one request outstanding at most
  bit    resp_pending = 1'b0;
  int    resp_cnt     = 0;
  addr_t resp_addr    = '0;
  int    gnt_wait     = -1;
  bit    slow_resp    = 1'b0;

  int cycle_cnt   = 0;
  int cycle_limit = 1000;

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .addr_i          (addr_i),
    .ready_i         (ready_i),
    .valid_o         (valid_o),
    .rdata_o         (rdata_o),
    .instr_req_o     (instr_req_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_addr_o    (instr_addr_o),
    .instr_rdata_i   (instr_rdata_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_err_pmp_i (instr_err_pmp_i),
    .fetch_failed_o  (fetch_failed_o),
    .busy_o          (busy_o)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // the word stored at an address, known to model and scoreboard alike
  function automatic word_t mem_word(input addr_t a);
    return word_t'(a) ^ DATA_KEY;
  endfunction

  function automatic bit is_protected(input addr_t a);
    foreach (protected_q[i]) begin
      if (protected_q[i] == a) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error: time %0t %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: time %0t %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // memory model and run limit
  ////////////////////////////////////////

  // response at +1, protection at +1, grant at +2, so the core side
  // stimulus of this negedge is settled before the memory reacts
  always @(negedge clk) begin
    #1;
    instr_rvalid_i = 1'b0;
    if (resp_pending) begin
      if (resp_cnt <= 1) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = mem_word(resp_addr);
        resp_pending   = 1'b0;
      end else begin
        resp_cnt = resp_cnt - 1;
      end
    end
    instr_err_pmp_i = is_protected(instr_addr_o);
    #1;
    instr_gnt_i = 1'b0;
    if (instr_req_o && !resp_pending) begin
      if (gnt_wait < 0) begin
        gnt_wait = int'($urandom_range(0, 3));
      end
      if (gnt_wait == 0) begin
        instr_gnt_i  = 1'b1;
        resp_pending = 1'b1;
        resp_addr    = instr_addr_o;
        resp_cnt     = slow_resp ? 2 : int'($urandom_range(1, 2));
        gnt_wait     = -1;
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Error: timeout after %0d cycles, the stream did not complete", cycle_cnt);
      abort_run();
    end
    if (DUT.u_props.assert_fails != 0) begin
      $display("Error: time %0t a protocol assertion failed", $time);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // command file
  ////////////////////////////////////////

  task automatic read_commands();
    int          fd;
    int          n;
    int          total;
    int          num;
    string       line;
    logic [63:0] cmd;
    addr_t       a;
    total = 0;
    fd = $fopen("bench/prefetch_input.txt", "r");
    if (fd == 0) begin
      $display("Error: the command file bench/prefetch_input.txt cannot be opened");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %d", cmd, a, num);
      if (n != 3) begin
        $display("Error: malformed command line: %s", line);
        abort_run();
      end
      if (cmd == "branch") begin
        cmd_kind.push_back(CMD_BRANCH);
        total = total + num * 12;
      end else if (cmd == "abort") begin
        cmd_kind.push_back(CMD_ABORT);
      end else if (cmd == "stall") begin
        cmd_kind.push_back(CMD_STALL);
        total = total + num;
      end else if (cmd == "pmp") begin
        cmd_kind.push_back(CMD_PMP);
      end else begin
        $display("Error: unknown command in line: %s", line);
        abort_run();
      end
      cmd_addr.push_back(a);
      cmd_num.push_back(num);
    end
    $fclose(fd);
    cycle_limit = total + 200;
  endtask

  ////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////

  // ready low for a while, the buffer must stop once the FIFO is full
  task automatic hold_ready_low(input int cycles);
    int grants;
    grants = 0;
    repeat (cycles) begin
      @(negedge clk);
      branch_i = 1'b0;
      ready_i  = 1'b0;
      #3;
      if (instr_req_o && instr_gnt_i) begin
        grants = grants + 1;
      end
    end
    if (grants > FIFO_DEPTH) begin
      $display("Error: %0d requests granted during a stall, more than the FIFO holds", grants);
      abort_run();
    end
    check_flag("instr_req_o", instr_req_o, 1'b0);
  endtask

  // the stream has reached a protected word, nothing may follow it
  task automatic expect_fetch_failed();
    int seen;
    seen = 0;
    while (seen < 4) begin
      @(negedge clk);
      branch_i = 1'b0;
      ready_i  = 1'b1;
      #3;
      if (valid_o) begin
        $display("Error: time %0t a word was delivered after a protection error", $time);
        abort_run();
      end
      if (fetch_failed_o) begin
        seen = seen + 1;
      end
    end
  endtask

  task automatic run_branch(input addr_t target, input int count, input bit aborting,
                            input int stall_cycles);
    addr_t exp_addr;
    int    k;
    int    stall_left;
    stall_left = stall_cycles;
    if (aborting) begin
      // start a throwaway stream, then branch while its response is in flight
      slow_resp = 1'b1;
      @(negedge clk);
      req_i    = 1'b1;
      branch_i = 1'b1;
      addr_i   = target + 32'h100;
      ready_i  = 1'b0;
      @(negedge clk);
      branch_i = 1'b0;
      while (!(resp_pending && resp_cnt == 2)) begin
        @(negedge clk);
      end
      slow_resp = 1'b0;
    end else begin
      @(negedge clk);
    end
    req_i    = 1'b1;
    branch_i = 1'b1;
    addr_i   = target;
    ready_i  = 1'b0;
    #3;
    check_flag("fetch_failed_o", fetch_failed_o, 1'b0);
    // a redirect either raises its request at once or waits on a pending response
    if (!is_protected(target)) begin
      check_flag("busy_o", busy_o, 1'b1);
    end
    exp_addr = target;
    k        = 0;
    while (k < count) begin
      if (is_protected(exp_addr)) begin
        expect_fetch_failed();
        k = count;
      end else begin
        if (stall_left > 0 && k == count / 2) begin
          hold_ready_low(stall_left);
          stall_left = 0;
        end
        @(negedge clk);
        branch_i = 1'b0;
        ready_i  = ($urandom_range(0, 3) != 0);
        #3;
        if (valid_o && ready_i) begin
          check_word("rdata_o", rdata_o, mem_word(exp_addr));
          exp_addr = exp_addr + ADDR_STEP;
          k        = k + 1;
        end
      end
    end
  endtask

  initial begin
    bit abort_next;
    int stall_next;
    abort_next = 1'b0;
    stall_next = 0;
    void'($urandom(32'h9050));
    clk             = 1'b0;
    rst_n           = 1'b0;
    req_i           = 1'b0;
    branch_i        = 1'b0;
    addr_i          = '0;
    ready_i         = 1'b0;
    instr_gnt_i     = 1'b0;
    instr_rdata_i   = '0;
    instr_rvalid_i  = 1'b0;
    instr_err_pmp_i = 1'b0;
    read_commands();

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #3;
    // quiet after reset as long as the core has not asked for anything
    check_flag("instr_req_o", instr_req_o, 1'b0);
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("fetch_failed_o", fetch_failed_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);

    foreach (cmd_kind[i]) begin
      case (cmd_kind[i])
        CMD_BRANCH: begin
          run_branch(cmd_addr[i], cmd_num[i], abort_next, stall_next);
          abort_next = 1'b0;
          stall_next = 0;
        end
        CMD_ABORT: abort_next = 1'b1;
        CMD_STALL: stall_next = cmd_num[i];
        default:   protected_q.push_back(cmd_addr[i]);
      endcase
    end

    @(negedge clk);
    ready_i = 1'b0;
    if (DUT.u_props.assert_fails == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Error: a protocol assertion failed during the run");
      abort_run();
    end
  end

endmodule

/* bench/prefetch_input.txt */
# command  address(hex)  count(dec)
# branch: target, words to consume / stall: -, cycles / abort: -, - / pmp: address, -
branch 00001000 6
stall 00000000 24
branch 00002000 10
abort 00000000 0
branch 00003000 5
pmp 00004010 0
branch 00004000 8
branch 00005000 4
abort 00000000 0
branch 00006000 3

/* sim.f */
rtl/mem_bus_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/instr_fifo.sv
rtl/resp_path.sv
rtl/prefetch_buffer.sv
bench/prefetch_props.sv
bench/tb_prefetch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the prefetch buffer simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
  -f sim.f --top-module tb_prefetch -o tb_prefetch_sim

./obj_dir/tb_prefetch_sim | tee sim.log || true

if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
